/* logic/lab_settings.svh */
`ifndef LAB_SETTINGS_SVH
`define LAB_SETTINGS_SVH

// operand and result width, fixed by the board switches
`define LAB_DATA_W 8

// seven-segment digits on the board
`define LAB_DIGITS 8

// lfsr escape value when the state is all zeros
`define LAB_LFSR_RELOAD 8'h01

// active low, so all ones means every segment and the dot are dark
`define LAB_SEG_BLANK 8'hff

`endif

/* logic/lab_ops_pkg.sv */
package lab_ops_pkg;

    // opcode taken from sw[14:12]
    typedef enum logic [2:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,
        op_and    = 3'd2,
        op_xor    = 3'd3,
        op_shl    = 3'd4,
        op_sra    = 3'd5,
        op_encode = 3'd6,
        op_lfsr   = 3'd7
    } lab_opcode_t;

    // single request slot in front of compute
    typedef enum logic {
        cap_empty = 1'b0,
        cap_full  = 1'b1
    } capture_state_t;

endpackage

/* logic/lab_disp_pkg.sv */
package lab_disp_pkg;

    // bit 7 is the decimal point, bits 6..0 are segments g..a
    // every bit is active low
    typedef logic [7:0] seg_pattern_t;

    // one nibble of the display word
    typedef logic [3:0] hex_digit_t;

endpackage

/* logic/lab_operand_capture.sv */
`timescale 1ns/1ps
`include "lab_settings.svh"

module lab_operand_capture (
    input  logic                     btn,
    input  logic                     rst,
    input  logic [15:0]              sw,
    input  logic                     go,
    output logic                     go_ready,
    output logic                     req_valid,
    input  logic                     req_ready,
    output logic [`LAB_DATA_W-1:0]   req_a,
    output logic [3:0]               req_b,
    output lab_ops_pkg::lab_opcode_t req_op
);
    import lab_ops_pkg::*;

    capture_state_t state;

    assign go_ready  = (state == cap_empty);
    assign req_valid = (state == cap_full);

    always_ff @(posedge btn) begin
        if (rst) begin
            state <= cap_empty;
        end else begin
            case (state)
                cap_empty: begin
                    if (go) begin
                        state <= cap_full;
                    end
                end
                cap_full: begin
                    // compute took it this edge
                    if (req_ready) begin
                        state <= cap_empty;
                    end
                end
                default: state <= cap_empty;
            endcase
        end
    end

    // switch fields sampled only when the slot is free
    always_ff @(posedge btn) begin
        if (go && go_ready) begin
            req_a  <= sw[7:0];
            req_b  <= sw[11:8];
            req_op <= lab_opcode_t'(sw[14:12]);
        end
    end

endmodule

/* logic/lab_compute.sv */
`timescale 1ns/1ps
`include "lab_settings.svh"

module lab_compute (
    input  logic                     btn,
    input  logic                     rst,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic [`LAB_DATA_W-1:0]   req_a,
    input  logic [3:0]               req_b,
    input  lab_ops_pkg::lab_opcode_t req_op,
    output logic                     res_valid,
    input  logic                     res_ready,
    output logic [31:0]              disp_word,
    output logic [`LAB_DATA_W-1:0]   result,
    output logic                     zero,
    output logic                     carry,
    output logic                     overflow,
    output logic                     found
);
    import lab_ops_pkg::*;

    logic [`LAB_DATA_W-1:0] lfsr_q;
    logic [`LAB_DATA_W-1:0] count_q;
    logic [`LAB_DATA_W-1:0] count_inc;
    logic [`LAB_DATA_W-1:0] b_ext;
    logic [2:0]             shamt;
    logic [`LAB_DATA_W:0]   sum_w;
    logic [`LAB_DATA_W:0]   diff_w;
    logic [2:0]             enc_idx;
    logic [`LAB_DATA_W-1:0] lfsr_next;
    logic [`LAB_DATA_W-1:0] res_c;
    logic                   carry_c;
    logic                   ovf_c;
    logic                   found_c;
    logic                   accept;

    // output stage empty or draining this cycle
    assign req_ready = !res_valid || res_ready;
    assign accept    = req_valid && req_ready;

    assign b_ext     = {{(`LAB_DATA_W-4){1'b0}}, req_b};
    assign shamt     = req_b[2:0];
    assign sum_w     = {1'b0, req_a} + {1'b0, b_ext};
    assign diff_w    = {1'b0, req_a} - {1'b0, b_ext};
    assign count_inc = count_q + 1'b1;

    // taps 4,3,2,0 feed the new msb
    assign lfsr_next = (lfsr_q == '0) ? `LAB_LFSR_RELOAD :
                       {lfsr_q[4] ^ lfsr_q[3] ^ lfsr_q[2] ^ lfsr_q[0], lfsr_q[7:1]};

    // highest set bit wins
    always_comb begin
        enc_idx = 3'd0;
        for (int i = 0; i < `LAB_DATA_W; i++) begin
            if (req_a[i]) begin
                enc_idx = i[2:0];
            end
        end
    end

    always_comb begin
        res_c   = '0;
        carry_c = 1'b0;
        ovf_c   = 1'b0;
        found_c = 1'b0;
        case (req_op)
            op_add: begin
                res_c   = sum_w[`LAB_DATA_W-1:0];
                carry_c = sum_w[`LAB_DATA_W];
                ovf_c   = (req_a[7] == b_ext[7]) && (sum_w[7] != req_a[7]);
            end
            op_sub: begin
                // borrow out when a < b
                res_c   = diff_w[`LAB_DATA_W-1:0];
                carry_c = diff_w[`LAB_DATA_W];
                ovf_c   = (req_a[7] != b_ext[7]) && (diff_w[7] != req_a[7]);
            end
            op_and:    res_c = req_a & b_ext;
            op_xor:    res_c = req_a ^ b_ext;
            op_shl:    res_c = req_a << shamt;
            op_sra:    res_c = $signed(req_a) >>> shamt;
            op_encode: begin
                res_c   = {{(`LAB_DATA_W-3){1'b0}}, enc_idx};
                found_c = |req_a;
            end
            op_lfsr:   res_c = lfsr_next;
            default:   res_c = '0;
        endcase
    end

    always_ff @(posedge btn) begin
        if (rst) begin
            res_valid <= 1'b0;
            lfsr_q    <= '0;
            count_q   <= '0;
        end else begin
            if (accept) begin
                res_valid <= 1'b1;
                count_q   <= count_inc;
                // other opcodes leave the generator alone
                if (req_op == op_lfsr) begin
                    lfsr_q <= lfsr_next;
                end
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge btn) begin
        if (accept) begin
            result    <= res_c;
            zero      <= (res_c == '0);
            carry     <= carry_c;
            overflow  <= ovf_c;
            found     <= found_c;
            // count, opcode, b, a, result from digit 7 down to 0
            disp_word <= {count_inc, 1'b0, req_op, req_b, req_a, res_c};
        end
    end

endmodule

/* logic/hex_segment_decoder.sv */
`timescale 1ns/1ps

module hex_segment_decoder (
    input  lab_disp_pkg::hex_digit_t   digit,
    output lab_disp_pkg::seg_pattern_t seg
);

    // dot stays dark, so bit 7 is always 1
    always_comb begin
        case (digit)
            4'h0:    seg = 8'hc0;
            4'h1:    seg = 8'hf9;
            4'h2:    seg = 8'ha4;
            4'h3:    seg = 8'hb0;
            4'h4:    seg = 8'h99;
            4'h5:    seg = 8'h92;
            4'h6:    seg = 8'h82;
            4'h7:    seg = 8'hf8;
            4'h8:    seg = 8'h80;
            4'h9:    seg = 8'h90;
            4'ha:    seg = 8'h88;
            // lower case b and d
            4'hb:    seg = 8'h83;
            4'hc:    seg = 8'hc6;
            4'hd:    seg = 8'ha1;
            4'he:    seg = 8'h86;
            4'hf:    seg = 8'h8e;
            default: seg = 8'hff;
        endcase
    end

endmodule

/* logic/lab_display_latch.sv */
`timescale 1ns/1ps
`include "lab_settings.svh"

module lab_display_latch (
    input  logic                       btn,
    input  logic                       rst,
    input  logic                       res_valid,
    output logic                       res_ready,
    input  logic                       freeze,
    input  lab_disp_pkg::seg_pattern_t seg_next0,
    input  lab_disp_pkg::seg_pattern_t seg_next1,
    input  lab_disp_pkg::seg_pattern_t seg_next2,
    input  lab_disp_pkg::seg_pattern_t seg_next3,
    input  lab_disp_pkg::seg_pattern_t seg_next4,
    input  lab_disp_pkg::seg_pattern_t seg_next5,
    input  lab_disp_pkg::seg_pattern_t seg_next6,
    input  lab_disp_pkg::seg_pattern_t seg_next7,
    input  logic [`LAB_DATA_W-1:0]     result,
    input  logic                       zero,
    input  logic                       carry,
    input  logic                       overflow,
    input  logic                       found,
    output logic                       updated,
    output logic [15:0]                ledr,
    output lab_disp_pkg::seg_pattern_t seg0,
    output lab_disp_pkg::seg_pattern_t seg1,
    output lab_disp_pkg::seg_pattern_t seg2,
    output lab_disp_pkg::seg_pattern_t seg3,
    output lab_disp_pkg::seg_pattern_t seg4,
    output lab_disp_pkg::seg_pattern_t seg5,
    output lab_disp_pkg::seg_pattern_t seg6,
    output lab_disp_pkg::seg_pattern_t seg7
);

    logic load;

    // freeze holds compute's result in place
    assign res_ready = !freeze;
    assign load      = res_valid && res_ready;

    always_ff @(posedge btn) begin
        if (rst) begin
            updated <= 1'b0;
            ledr    <= '0;
            seg0    <= `LAB_SEG_BLANK;
            seg1    <= `LAB_SEG_BLANK;
            seg2    <= `LAB_SEG_BLANK;
            seg3    <= `LAB_SEG_BLANK;
            seg4    <= `LAB_SEG_BLANK;
            seg5    <= `LAB_SEG_BLANK;
            seg6    <= `LAB_SEG_BLANK;
            seg7    <= `LAB_SEG_BLANK;
        end else begin
            updated <= load;
            if (load) begin
                // upper four leds stay dark
                ledr <= {4'b0000, found, overflow, carry, zero, result};
                seg0 <= seg_next0;
                seg1 <= seg_next1;
                seg2 <= seg_next2;
                seg3 <= seg_next3;
                seg4 <= seg_next4;
                seg5 <= seg_next5;
                seg6 <= seg_next6;
                seg7 <= seg_next7;
            end
        end
    end

endmodule

/* logic/lab_board_top.sv */
`timescale 1ns/1ps
`include "lab_settings.svh"

module lab_board_top (
    input  logic                       btn,
    input  logic                       rst,
    input  logic [15:0]                sw,
    input  logic                       go,
    input  logic                       freeze,
    output logic                       go_ready,
    output logic                       updated,
    output logic [15:0]                ledr,
    output lab_disp_pkg::seg_pattern_t seg0,
    output lab_disp_pkg::seg_pattern_t seg1,
    output lab_disp_pkg::seg_pattern_t seg2,
    output lab_disp_pkg::seg_pattern_t seg3,
    output lab_disp_pkg::seg_pattern_t seg4,
    output lab_disp_pkg::seg_pattern_t seg5,
    output lab_disp_pkg::seg_pattern_t seg6,
    output lab_disp_pkg::seg_pattern_t seg7
);
    import lab_ops_pkg::*;
    import lab_disp_pkg::*;

    logic                   req_valid;
    logic                   req_ready;
    logic [`LAB_DATA_W-1:0] req_a;
    logic [3:0]             req_b;
    lab_opcode_t            req_op;
    logic                   res_valid;
    logic                   res_ready;
    logic [31:0]            disp_word;
    logic [`LAB_DATA_W-1:0] result;
    logic                   zero;
    logic                   carry;
    logic                   overflow;
    logic                   found;
    seg_pattern_t           seg_next [`LAB_DIGITS];

    lab_operand_capture u_capture (
        .btn       (btn),
        .rst       (rst),
        .sw        (sw),
        .go        (go),
        .go_ready  (go_ready),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_op    (req_op)
    );

    lab_compute u_compute (
        .btn       (btn),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_op    (req_op),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .disp_word (disp_word),
        .result    (result),
        .zero      (zero),
        .carry     (carry),
        .overflow  (overflow),
        .found     (found)
    );

    // digit k shows nibble k of the display word
    for (genvar k = 0; k < `LAB_DIGITS; k++) begin : g_digit
        hex_segment_decoder u_dec (
            .digit (disp_word[4*k +: 4]),
            .seg   (seg_next[k])
        );
    end

    lab_display_latch u_latch (
        .btn       (btn),
        .rst       (rst),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .freeze    (freeze),
        .seg_next0 (seg_next[0]),
        .seg_next1 (seg_next[1]),
        .seg_next2 (seg_next[2]),
        .seg_next3 (seg_next[3]),
        .seg_next4 (seg_next[4]),
        .seg_next5 (seg_next[5]),
        .seg_next6 (seg_next[6]),
        .seg_next7 (seg_next[7]),
        .result    (result),
        .zero      (zero),
        .carry     (carry),
        .overflow  (overflow),
        .found     (found),
        .updated   (updated),
        .ledr      (ledr),
        .seg0      (seg0),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3),
        .seg4      (seg4),
        .seg5      (seg5),
        .seg6      (seg6),
        .seg7      (seg7)
    );

endmodule

/* testbench/lab_board_checker.sv */
`timescale 1ns/1ps
`include "lab_settings.svh"

module lab_board_checker (
    input  logic        btn,
    input  logic        rst,
    input  logic [15:0] sw,
    input  logic        go,
    input  logic        go_ready,
    input  logic        updated,
    input  logic [15:0] ledr,
    input  logic [63:0] segs,
    output int          errors,
    output int          checks,
    output int          pending
);
    import lab_ops_pkg::*;

    // active-low digit patterns, f at the top down to 0 at the bottom
    localparam logic [127:0] seg_table = {64'h8e86a1c683889080, 64'hf8829299b0a4f9c0};

    logic [79:0] expected_q [$];
    logic [7:0]  lfsr_model;
    logic [7:0]  count_model;
    logic [79:0] want;

    function automatic logic [7:0] lfsr_advance(input logic [7:0] s);
        if (s == 8'h00) begin
            return `LAB_LFSR_RELOAD;
        end
        return {s[4] ^ s[3] ^ s[2] ^ s[0], s[7:1]};
    endfunction

    // expected {ledr, seg7 .. seg0} for one operation
    function automatic logic [79:0] reference_display(input logic [7:0] a, input logic [3:0] b,
            input lab_opcode_t op, input logic [7:0] lfsr_now, input logic [7:0] count);
        logic [7:0]  res;
        logic [15:0] ext;
        logic [31:0] word;
        logic [63:0] pattern;
        logic        cy;
        logic        ov;
        int          ua;
        int          sa;
        int          ib;
        int          wide;
        int          k;
        res = 8'h00;
        cy = 1'b0;
        ov = 1'b0;
        ua = a;
        sa = $signed(a);
        ib = b;
        case (op)
            op_add: begin
                res = ua + ib;
                cy = (ua + ib) > 255;
                wide = sa + ib;
                ov = (wide > 127) || (wide < -128);
            end
            op_sub: begin
                res = ua - ib;
                cy = ua < ib;
                wide = sa - ib;
                ov = (wide > 127) || (wide < -128);
            end
            op_and: res = a & {4'h0, b};
            op_xor: res = a ^ {4'h0, b};
            op_shl: res = a << b[2:0];
            op_sra: begin
                ext = {{8{a[7]}}, a} >> b[2:0];
                res = ext[7:0];
            end
            op_encode: begin
                for (k = 0; k < 8; k++) begin
                    if (a[k]) begin
                        res = k;
                    end
                end
            end
            default: res = lfsr_advance(lfsr_now);
        endcase
        word = {count, 1'b0, op, b, a, res};
        for (k = 0; k < 8; k++) begin
            pattern[8*k +: 8] = seg_table[8*word[4*k +: 4] +: 8];
        end
        return {4'h0, (op == op_encode) && (a != 8'h00), ov, cy, res == 8'h00, res, pattern};
    endfunction

    always @(posedge btn) begin
        if (rst) begin
            expected_q.delete();
            lfsr_model = 8'h00;
            count_model = 8'h00;
            errors = 0;
            checks = 0;
        end else begin
            if (updated) begin
                if (expected_q.size() == 0) begin
                    $display("display updated at %0t ns with no operation outstanding", $time);
                    errors++;
                end else begin
                    want = expected_q.pop_front();
                    checks++;
                    if ({ledr, segs} !== want) begin
                        errors++;
                        $display("MISMATCH at %0t ns: ledr %h segs %h, expected ledr %h segs %h",
                                 $time, ledr, segs, want[79:64], want[63:0]);
                    end
                end
            end
            // a go transfer fixes the order of everything shown later
            if (go && go_ready) begin
                count_model = count_model + 8'd1;
                expected_q.push_back(reference_display(sw[7:0], sw[11:8],
                                     lab_opcode_t'(sw[14:12]), lfsr_model, count_model));
                if (sw[14:12] == op_lfsr) begin
                    lfsr_model = lfsr_advance(lfsr_model);
                end
            end
        end
        pending = expected_q.size();
    end

endmodule

/* testbench/lab_board_tb.sv */
`timescale 1ns/1ps
`include "lab_settings.svh"

module lab_board_tb;
    import lab_ops_pkg::*;

    localparam int wait_limit = 64;

    logic        btn;
    logic        rst;
    logic [15:0] sw;
    logic        go;
    logic        freeze;
    logic        go_ready;
    logic        updated;
    logic [15:0] ledr;
    logic [7:0]  seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7;
    wire  [63:0] segs = {seg7, seg6, seg5, seg4, seg3, seg2, seg1, seg0};
    int          errors;
    int          checks;
    int          pending;
    int          seed;
    int          tb_failures;
    int          failures_before;
    int          tests_clean;
    int          accepted;
    int          quiet;
    int          tries;
    logic [31:0] r;

    lab_board_top DUT (.*);

    lab_board_checker u_checker (.*);

    always #20 btn = ~btn;

    task automatic step();
        @(posedge btn);
        #2;
    endtask

    task automatic expect_value(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            tb_failures++;
        end
    endtask

    task automatic wait_go_ready();
        int n;
        n = 0;
        while (!go_ready && n < wait_limit) begin
            step();
            n++;
        end
        if (!go_ready) begin
            $display("timeout at %0t ns: go_ready stayed low", $time);
            tb_failures++;
        end
    endtask

    task automatic issue_op(input lab_opcode_t op, input logic [7:0] a, input logic [3:0] b);
        wait_go_ready();
        sw = {1'b0, op, b, a};
        go = 1'b1;
        step();
        go = 1'b0;
    endtask

    // every accepted operation has to reach the display
    task automatic drain();
        int n;
        n = 0;
        while (pending != 0 && n < wait_limit) begin
            step();
            n++;
        end
        if (pending != 0) begin
            $display("timeout at %0t ns: %0d operations never reached the display",
                     $time, pending);
            tb_failures++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        int fails;
        drain();
        fails = tb_failures + errors - failures_before;
        if (fails == 0) begin
            tests_clean++;
        end
        $display("test %0d %s: %0d updates checked so far, %0d new failures",
                 num, name, checks, fails);
        failures_before = tb_failures + errors;
    endtask

    initial begin
        btn = 1'b0;
        rst = 1'b1;
        sw = 16'h0000;
        go = 1'b0;
        freeze = 1'b0;
        seed = 14330;
        tb_failures = 0;
        failures_before = 0;
        tests_clean = 0;
        repeat (16) step();
        rst = 1'b0;

        expect_value("segments", segs, {8{`LAB_SEG_BLANK}});
        expect_value("ledr", ledr, 16'h0000);
        expect_value("go_ready", go_ready, 1'b1);
        expect_value("updated", updated, 1'b0);
        end_test(1, "reset state");

        repeat (40) begin
            r = $random(seed);
            issue_op(lab_opcode_t'(r[17:16]), r[7:0], r[11:8]);
        end
        // carry, borrow and overflow corners that random operands rarely hit
        issue_op(op_add, 8'hff, 4'h1);
        issue_op(op_add, 8'h7f, 4'h1);
        issue_op(op_sub, 8'h00, 4'h1);
        issue_op(op_sub, 8'h80, 4'h1);
        issue_op(op_sub, 8'h05, 4'h5);
        issue_op(op_xor, 8'h0c, 4'hc);
        end_test(2, "add sub and xor");

        // b bit 3 is noise for the shifter but still shows on digit 4
        for (int s = 0; s < 8; s++) begin
            r = $random(seed);
            issue_op(op_shl, r[7:0] | 8'h80, {r[16], s[2:0]});
            issue_op(op_sra, r[7:0] | 8'h80, {r[17], s[2:0]});
            issue_op(op_shl, r[15:8] & 8'h7f, {r[18], s[2:0]});
            issue_op(op_sra, r[15:8] & 8'h7f, {r[19], s[2:0]});
        end
        end_test(3, "shl and sra");

        issue_op(op_encode, 8'h00, 4'h0);
        for (int i = 0; i < 8; i++) begin
            issue_op(op_encode, 8'h01 << i, i[3:0]);
        end
        repeat (16) begin
            r = $random(seed);
            issue_op(op_encode, r[7:0], r[11:8]);
        end
        end_test(4, "priority encode");

        // no lfsr step so far, so the generator still holds zero
        issue_op(op_lfsr, 8'h00, 4'h0);
        drain();
        expect_value("first lfsr result", ledr[7:0], 8'h01);
        repeat (24) begin
            r = $random(seed);
            issue_op(op_lfsr, r[7:0], r[11:8]);
            issue_op((r[18:16] == 3'd7) ? op_add : lab_opcode_t'(r[18:16]), r[15:8], r[23:20]);
        end
        end_test(5, "lfsr sequence");

        drain();
        freeze = 1'b1;
        accepted = 0;
        quiet = 0;
        tries = 0;
        while (quiet < 4 && tries < wait_limit) begin
            if (updated) begin
                $display("display updated at %0t ns while frozen", $time);
                tb_failures++;
            end
            go = go_ready;
            if (go_ready) begin
                r = $random(seed);
                sw = r[15:0];
                accepted++;
                quiet = 0;
            end else begin
                quiet++;
            end
            tries++;
            step();
        end
        go = 1'b0;
        if (quiet < 4) begin
            $display("timeout at %0t ns: go_ready never stayed low under freeze", $time);
            tb_failures++;
        end
        expect_value("operations accepted under freeze", accepted, 2);
        expect_value("operations outstanding", pending, 2);
        freeze = 1'b0;
        end_test(6, "freeze back-pressure");

        $display("%0d updates checked, %0d failures, %0d of 6 tests clean",
                 checks, tb_failures + errors, tests_clean);
        if (tb_failures + errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/lab_ops_pkg.sv
logic/lab_disp_pkg.sv
logic/lab_operand_capture.sv
logic/lab_compute.sv
logic/hex_segment_decoder.sv
logic/lab_display_latch.sv
logic/lab_board_top.sv
testbench/lab_board_checker.sv
testbench/lab_board_tb.sv
